/* tb.f */
vseq_pkg.sv
vseq_issue_if.sv
vseq_decode.sv
vseq_sequencer.sv
vseq_pe.sv
vseq_result.sv
vseq_top.sv
tb_vseq.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_vseq -o sim_vseq

out=$(./obj_dir/sim_vseq)
echo "$out"

echo "$out" | grep -q "Test passed"

/* tb_vseq.sv */
// Testbench of the vector sequencer subsystem.
// Applies a table of dispatcher requests in groups, checks the responses in
// program order, then checks back-pressure with more instructions than ids.
`timescale 1ns/1ps

module tb_vseq;

  localparam int unsigned MAX_ENTRIES = 16;
  localparam int unsigned TIMEOUT = 2000;
  // Shortest lifetime of a vl 200 VMUL: one hazard cycle plus vl + 4
  localparam int unsigned VMUL_LIFE = 205;

  typedef struct packed {
    vseq_pkg::op_e op;
    vseq_pkg::vreg_t vd;
    vseq_pkg::vreg_t vs1;
    vseq_pkg::vreg_t vs2;
    logic vm;
    vseq_pkg::vl_t vl;
    vseq_pkg::elen_t scalar;
    logic exp_resp;
    vseq_pkg::elen_t exp_data;
    logic exp_err;
    logic last;  // ends a group, which is followed by a wait for idle
  } entry_t;

  logic clk_i;
  logic rst_ni;
  logic req_valid_i;
  vseq_pkg::op_e req_op_i;
  vseq_pkg::vreg_t req_vd_i;
  vseq_pkg::vreg_t req_vs1_i;
  vseq_pkg::vreg_t req_vs2_i;
  logic req_vm_i;
  vseq_pkg::vl_t req_vl_i;
  vseq_pkg::elen_t req_scalar_i;
  logic req_ready_o;
  logic resp_valid_o;
  vseq_pkg::elen_t resp_data_o;
  logic resp_error_o;
  logic idle_o;

  entry_t tbl [MAX_ENTRIES];
  string tbl_name [MAX_ENTRIES];
  int unsigned n_entries = 0;
  int unsigned n_pass = 0;
  int unsigned n_fail = 0;
  int unsigned cycle = 0;
  logic aborted = 1'b0;
  integer seed;
  vseq_pkg::elen_t resp_data_q [$];
  logic resp_err_q [$];

  vseq_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // Responses are collected mid-cycle, in arrival order
  always @(negedge clk_i) begin
    if (resp_valid_o) begin
      resp_data_q.push_back(resp_data_o);
      resp_err_q.push_back(resp_error_o);
    end
  end

  task automatic add_entry(input string name, input vseq_pkg::op_e op,
                           input vseq_pkg::vreg_t vd, input vseq_pkg::vreg_t vs1,
                           input vseq_pkg::vreg_t vs2, input logic vm,
                           input vseq_pkg::vl_t vl, input vseq_pkg::elen_t scalar,
                           input logic exp_resp, input vseq_pkg::elen_t exp_data,
                           input logic exp_err, input logic last);
    tbl_name[n_entries] = name;
    tbl[n_entries] = {op, vd, vs1, vs2, vm, vl, scalar, exp_resp, exp_data, exp_err, last};
    n_entries++;
  endtask

  task automatic drive_fields(input vseq_pkg::op_e op, input vseq_pkg::vreg_t vd,
                              input vseq_pkg::vreg_t vs1, input vseq_pkg::vreg_t vs2,
                              input logic vm, input vseq_pkg::vl_t vl,
                              input vseq_pkg::elen_t scalar);
    req_valid_i <= 1'b1;
    req_op_i <= op;
    req_vd_i <= vd;
    req_vs1_i <= vs1;
    req_vs2_i <= vs2;
    req_vm_i <= vm;
    req_vl_i <= vl;
    req_scalar_i <= scalar;
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    n_fail++;
    aborted = 1'b1;
  endtask

  // Ready seen mid-cycle means the request is taken on the next rising edge
  task automatic wait_ready(output logic ok);
    int unsigned t;
    t = 0;
    ok = 1'b0;
    while (!ok && t < TIMEOUT) begin
      @(negedge clk_i);
      if (req_ready_o) ok = 1'b1;
      t++;
    end
  endtask

  // Two more edges let a response that comes with the last done be collected
  task automatic wait_idle(output logic ok);
    int unsigned t;
    t = 0;
    ok = 1'b0;
    while (!ok && t < TIMEOUT) begin
      @(negedge clk_i);
      if (idle_o) ok = 1'b1;
      t++;
    end
    repeat (2) @(posedge clk_i);
  endtask

  task automatic send_entry(input int unsigned idx);
    logic ok;
    @(posedge clk_i);
    drive_fields(tbl[idx].op, tbl[idx].vd, tbl[idx].vs1, tbl[idx].vs2,
                 tbl[idx].vm, tbl[idx].vl, tbl[idx].scalar);
    wait_ready(ok);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    if (!ok) abort_run($sformatf("request %s was never accepted", tbl_name[idx]));
  endtask

  task automatic check_group(input int unsigned first, input int unsigned last_idx);
    vseq_pkg::elen_t data;
    logic err;
    for (int unsigned k = first; k <= last_idx; k++) begin
      if (!tbl[k].exp_resp) begin
        $display("PASS %s", tbl_name[k]);
        n_pass++;
      end else if (resp_data_q.size() == 0) begin
        $display("%s expected a response but none arrived", tbl_name[k]);
        n_fail++;
      end else begin
        data = resp_data_q.pop_front();
        err = resp_err_q.pop_front();
        if (data !== tbl[k].exp_data || err !== tbl[k].exp_err) begin
          $display("FAILED %s: expected data %h error %b, actual data %h error %b",
                   tbl_name[k], tbl[k].exp_data, tbl[k].exp_err, data, err);
          n_fail++;
        end else begin
          $display("PASS %s", tbl_name[k]);
          n_pass++;
        end
      end
    end
    if (resp_data_q.size() != 0) begin
      $display("%0d responses arrived that no request of the group up to %s asked for",
               resp_data_q.size(), tbl_name[last_idx]);
      n_fail++;
      resp_data_q.delete();
      resp_err_q.delete();
    end
  endtask

  // Six independent VMULs with valid held; ids are reused only after retiring
  task automatic run_backpressure();
    int unsigned acc_cycle [6];
    int unsigned n_acc;
    logic ok;
    logic bad;
    n_acc = 0;
    ok = 1'b1;
    bad = 1'b0;
    @(posedge clk_i);
    drive_fields(vseq_pkg::VMUL, 5'd10, 5'd16, 5'd22, 1'b1, 8'd200, '0);
    while (ok && n_acc < 6) begin
      wait_ready(ok);
      if (ok) begin
        acc_cycle[n_acc] = cycle;
        n_acc++;
        @(posedge clk_i);
        if (n_acc < 6) begin
          drive_fields(vseq_pkg::VMUL, vseq_pkg::vreg_t'(10 + n_acc),
                       vseq_pkg::vreg_t'(16 + n_acc), vseq_pkg::vreg_t'(22 + n_acc),
                       1'b1, 8'd200, '0);
        end else begin
          req_valid_i <= 1'b0;
        end
      end
    end
    if (!ok) begin
      req_valid_i <= 1'b0;
      abort_run($sformatf("backpressure: only %0d of 6 VMULs were accepted", n_acc));
      return;
    end
    for (int unsigned i = 0; i < 2; i++) begin
      if (acc_cycle[i + 4] - acc_cycle[i] < VMUL_LIFE) begin
        $display("FAILED backpressure: expected at most 4 accepts in %0d cycles, actual 5 in %0d",
                 VMUL_LIFE, acc_cycle[i + 4] - acc_cycle[i]);
        bad = 1'b1;
      end
    end
    wait_idle(ok);
    if (!ok) begin
      abort_run("backpressure: idle_o never returned high");
    end else if (resp_data_q.size() != 0) begin
      $display("backpressure: VMUL produced %0d responses", resp_data_q.size());
      n_fail++;
    end else if (bad) begin
      n_fail++;
    end else begin
      $display("PASS backpressure");
      n_pass++;
    end
  endtask

  initial begin
    logic ok;
    int unsigned first;
    integer rand_val;
    vseq_pkg::vl_t rvl;
    seed = 32'hb1b4_86f0;
    rst_ni = 1'b0;
    drive_fields(vseq_pkg::VADD, '0, '0, '0, 1'b1, '0, '0);
    req_valid_i <= 1'b0;

    add_entry("vle_aligned", vseq_pkg::VLE, 5'd4, 5'd0, 5'd0, 1'b1, 8'd8, 32'h1000,
              1'b1, 32'd0, 1'b0, 1'b1);
    add_entry("vle_misaligned", vseq_pkg::VLE, 5'd5, 5'd0, 5'd0, 1'b1, 8'd8, 32'h1002,
              1'b1, 32'd0, 1'b1, 1'b1);
    add_entry("vse_aligned", vseq_pkg::VSE, 5'd0, 5'd4, 5'd0, 1'b1, 8'd12, 32'h2000,
              1'b1, 32'd0, 1'b0, 1'b1);
    add_entry("vse_misaligned", vseq_pkg::VSE, 5'd0, 5'd6, 5'd0, 1'b1, 8'd12, 32'h2003,
              1'b1, 32'd0, 1'b1, 1'b1);
    add_entry("vredsum_fixed", vseq_pkg::VREDSUM, 5'd0, 5'd0, 5'd7, 1'b1, 8'd16, 32'd100,
              1'b1, 32'd100 + 32'd16, 1'b0, 1'b1);
    rand_val = $random(seed);
    rvl = rand_val[7:0];
    add_entry("vredsum_random_vl", vseq_pkg::VREDSUM, 5'd0, 5'd0, 5'd8, 1'b1, rvl,
              32'h0001_0000, 1'b1, 32'h0001_0000 + {24'd0, rvl}, 1'b0, 1'b1);
    add_entry("vadd", vseq_pkg::VADD, 5'd9, 5'd10, 5'd11, 1'b1, 8'd20, '0,
              1'b0, '0, 1'b0, 1'b1);
    add_entry("vmul", vseq_pkg::VMUL, 5'd12, 5'd13, 5'd14, 1'b1, 8'd30, '0,
              1'b0, '0, 1'b0, 1'b1);
    // Dependent chain with RAW on v1 and v2, WAR on v3 and WAW on v2
    add_entry("chain_vle_v1", vseq_pkg::VLE, 5'd1, 5'd0, 5'd0, 1'b1, 8'd24, 32'h3000,
              1'b1, 32'd0, 1'b0, 1'b0);
    add_entry("chain_vadd_v2", vseq_pkg::VADD, 5'd2, 5'd1, 5'd3, 1'b1, 8'd24, '0,
              1'b0, '0, 1'b0, 1'b0);
    add_entry("chain_vle_v3", vseq_pkg::VLE, 5'd3, 5'd0, 5'd0, 1'b1, 8'd24, 32'h3101,
              1'b1, 32'd0, 1'b1, 1'b0);
    add_entry("chain_vadd_v2_masked", vseq_pkg::VADD, 5'd2, 5'd3, 5'd4, 1'b0, 8'd24, '0,
              1'b0, '0, 1'b0, 1'b0);
    add_entry("chain_vredsum_v2", vseq_pkg::VREDSUM, 5'd0, 5'd0, 5'd2, 1'b1, 8'd24, 32'd7,
              1'b1, 32'd7 + 32'd24, 1'b0, 1'b1);

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (idle_o !== 1'b1 || resp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
      $display("FAILED reset: expected idle/resp_valid/ready 101, actual %b%b%b",
               idle_o, resp_valid_o, req_ready_o);
      n_fail++;
    end else begin
      $display("PASS reset");
      n_pass++;
    end

    first = 0;
    for (int unsigned i = 0; i < n_entries && !aborted; i++) begin
      send_entry(i);
      if (!aborted && tbl[i].last) begin
        wait_idle(ok);
        if (!ok) abort_run($sformatf("idle_o never returned high after %s", tbl_name[i]));
        else check_group(first, i);
        first = i + 1;
      end
    end
    if (!aborted) run_backpressure();

    $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vseq_top.sv */
// Top level of the vector sequencer subsystem with the dispatcher ports.
// Wires decode, sequencer, the three processing elements and the result.
`timescale 1ns/1ps

module vseq_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_valid_i,
  input  vseq_pkg::op_e    req_op_i,
  input  vseq_pkg::vreg_t  req_vd_i,
  input  vseq_pkg::vreg_t  req_vs1_i,
  input  vseq_pkg::vreg_t  req_vs2_i,
  input  logic             req_vm_i,
  input  vseq_pkg::vl_t    req_vl_i,
  input  vseq_pkg::elen_t  req_scalar_i,
  output logic             req_ready_o,
  output logic             resp_valid_o,
  output vseq_pkg::elen_t  resp_data_o,
  output logic             resp_error_o,
  output logic             idle_o
);

  vseq_issue_if dec_if ();
  vseq_issue_if iss_if ();

  logic [vseq_pkg::NR_PES-1:0] pe_ready;
  logic [vseq_pkg::NR_PES-1:0] pe_ack;
  logic [vseq_pkg::NR_PES-1:0] pe_err;
  logic [vseq_pkg::NR_PES-1:0] pe_scalar_valid;
  vseq_pkg::vmask_t [vseq_pkg::NR_PES-1:0] pe_done;
  vseq_pkg::elen_t [vseq_pkg::NR_PES-1:0] pe_scalar;
  vseq_pkg::vmask_t done;
  logic resp_event;

  assign dec_if.valid = req_valid_i;

  vseq_decode i_decode (
    .decoded  (dec_if.dec_mp),
    .op_i     (req_op_i),
    .vd_i     (req_vd_i),
    .vs1_i    (req_vs1_i),
    .vs2_i    (req_vs2_i),
    .vm_i     (req_vm_i),
    .vl_i     (req_vl_i),
    .scalar_i (req_scalar_i)
  );

  vseq_sequencer i_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .dec          (dec_if.seq_in_mp),
    .issue        (iss_if.seq_out_mp),
    .pe_ready_i   (pe_ready),
    .done_i       (done),
    .resp_event_i (resp_event),
    .idle_o       (idle_o)
  );

  // Element index equals the unit encoding
  for (genvar p = 0; p < vseq_pkg::NR_PES; p++) begin : g_pe
    vseq_pe i_pe (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .issue          (iss_if.pe_mp),
      .unit_i         (vseq_pkg::unit_e'(p)),
      .ready_o        (pe_ready[p]),
      .done_o         (pe_done[p]),
      .ack_o          (pe_ack[p]),
      .err_o          (pe_err[p]),
      .scalar_valid_o (pe_scalar_valid[p]),
      .scalar_o       (pe_scalar[p])
    );
  end

  vseq_result i_result (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .done_i         (pe_done),
    .ack_i          (pe_ack),
    .err_i          (pe_err),
    .scalar_valid_i (pe_scalar_valid[vseq_pkg::PE_ALU]),
    .scalar_i       (pe_scalar[vseq_pkg::PE_ALU]),
    .done_o         (done),
    .resp_event_o   (resp_event),
    .resp_valid_o   (resp_valid_o),
    .resp_data_o    (resp_data_o),
    .resp_error_o   (resp_error_o)
  );

endmodule

/* vseq_result.sv */
// Merges done reports of the elements and builds the dispatcher response
// from the address acknowledgement or the scalar reduction result.
`timescale 1ns/1ps

module vseq_result (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  vseq_pkg::vmask_t [vseq_pkg::NR_PES-1:0]    done_i,
  input  logic [vseq_pkg::NR_PES-1:0]                ack_i,
  input  logic [vseq_pkg::NR_PES-1:0]                err_i,
  input  logic                                       scalar_valid_i,
  input  vseq_pkg::elen_t                            scalar_i,
  output vseq_pkg::vmask_t                           done_o,
  output logic                                       resp_event_o,
  output logic                                       resp_valid_o,
  output vseq_pkg::elen_t                            resp_data_o,
  output logic                                       resp_error_o
);

  logic ack;
  logic err;

  always_comb begin
    done_o = '0;
    for (int p = 0; p < vseq_pkg::NR_PES; p++) begin
      done_o |= done_i[p];
    end
  end

  // Only load and store answer with an address acknowledgement
  assign ack = ack_i[vseq_pkg::PE_LOAD] | ack_i[vseq_pkg::PE_STORE];
  assign err = (ack_i[vseq_pkg::PE_LOAD] & err_i[vseq_pkg::PE_LOAD]) |
               (ack_i[vseq_pkg::PE_STORE] & err_i[vseq_pkg::PE_STORE]);
  assign resp_event_o = ack | scalar_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= resp_event_o;
    end
  end

  // Ack wins; at most one response is outstanding anyway
  always_ff @(posedge clk_i) begin
    if (resp_event_o) begin
      resp_data_o <= ack ? '0 : scalar_i;
      resp_error_o <= ack ? err : 1'b0;
    end
  end

endmodule

/* vseq_pe.sv */
// Processing element, one instance per execution unit.
// Waits for its hazards to retire, counts out the vector length and
// reports its id as done. Load and store also acknowledge the address.
`timescale 1ns/1ps

module vseq_pe (
  input  logic              clk_i,
  input  logic              rst_ni,
  vseq_issue_if.pe_mp       issue,
  input  vseq_pkg::unit_e   unit_i,
  output logic              ready_o,
  output vseq_pkg::vmask_t  done_o,
  output logic              ack_o,
  output logic              err_o,
  output logic              scalar_valid_o,
  output vseq_pkg::elen_t   scalar_o
);

  typedef enum logic [1:0] {
    PE_IDLE,
    PE_HAZARD,
    PE_RUN
  } state_e;

  state_e state_q;
  logic accept;
  logic [8:0] cnt_q;
  vseq_pkg::vid_t id_q;
  vseq_pkg::vmask_t hazard_q;
  logic redsum_q;
  vseq_pkg::elen_t result_q;

  // Only a request for this unit can block the issue
  assign ready_o = (state_q == PE_IDLE) || (issue.unit != unit_i);
  assign accept = issue.valid && (issue.unit == unit_i) && (state_q == PE_IDLE);
  assign scalar_o = result_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PE_IDLE;
      cnt_q <= '0;
      hazard_q <= '0;
      redsum_q <= 1'b0;
      done_o <= '0;
      ack_o <= 1'b0;
      err_o <= 1'b0;
      scalar_valid_o <= 1'b0;
    end else begin
      done_o <= '0;
      ack_o <= 1'b0;
      err_o <= 1'b0;
      scalar_valid_o <= 1'b0;
      case (state_q)
        PE_IDLE: begin
          if (accept) begin
            state_q <= PE_HAZARD;
            hazard_q <= issue.hazard;
            // Multiplier pipeline adds three cycles
            cnt_q <= {1'b0, issue.vl} + ((issue.op == vseq_pkg::VMUL) ? 9'd4 : 9'd1);
            redsum_q <= issue.op == vseq_pkg::VREDSUM;
            ack_o <= unit_i != vseq_pkg::UNIT_ALU;
            // Word alignment check on the base address
            err_o <= (unit_i != vseq_pkg::UNIT_ALU) && (issue.scalar[1:0] != 2'b00);
          end
        end
        PE_HAZARD: begin
          // Retired ids drop out so a reused id is never waited on
          hazard_q <= hazard_q & issue.running;
          if (~|(hazard_q & issue.running)) state_q <= PE_RUN;
        end
        PE_RUN: begin
          cnt_q <= cnt_q - 9'd1;
          if (cnt_q == 9'd1) begin
            state_q <= PE_IDLE;
            done_o <= vseq_pkg::vmask_t'(1) << id_q;
            scalar_valid_o <= redsum_q;
          end
        end
        default: state_q <= PE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q <= issue.id;
      result_q <= issue.scalar + vseq_pkg::elen_t'(issue.vl);
    end
  end

  // Done names exactly one id, and the sequencer still counts it running
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    |done_o |-> $onehot(done_o) && ((done_o & issue.running) == done_o));

endmodule

/* vseq_sequencer.sv */
// Instruction sequencer: hands out ids, tracks running instructions
// and register access lists, builds hazard masks and issues one request
// at a time to the processing elements.
`timescale 1ns/1ps

module vseq_sequencer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  vseq_issue_if.seq_in_mp                dec,
  vseq_issue_if.seq_out_mp               issue,
  input  logic [vseq_pkg::NR_PES-1:0]    pe_ready_i,
  input  vseq_pkg::vmask_t               done_i,
  input  logic                           resp_event_i,
  output logic                           idle_o
);

  // WAIT holds the dispatcher until the response event arrives
  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e state_d, state_q;

  vseq_pkg::vmask_t [vseq_pkg::NR_PES-1:0] pe_running_d, pe_running_q;
  vseq_pkg::vmask_t running_d, running_q;
  vseq_pkg::vmask_t live;

  // Last reader and last writer of each vector register
  vseq_pkg::vid_t [31:0] rd_vid_d, rd_vid_q;
  vseq_pkg::vid_t [31:0] wr_vid_d, wr_vid_q;
  logic [31:0] rd_valid_d, rd_valid_q;
  logic [31:0] wr_valid_d, wr_valid_q;

  vseq_pkg::vid_t next_id;
  logic full;
  logic stall;
  logic accept;

  logic valid_d;
  vseq_pkg::vid_t id_d;
  vseq_pkg::op_e op_d;
  vseq_pkg::unit_e unit_d;
  vseq_pkg::vl_t vl_d;
  vseq_pkg::elen_t scalar_d;
  vseq_pkg::vmask_t hazard_d;

  function automatic int unsigned pe_idx(vseq_pkg::unit_e unit);
    case (unit)
      vseq_pkg::UNIT_LOAD: pe_idx = vseq_pkg::PE_LOAD;
      vseq_pkg::UNIT_STORE: pe_idx = vseq_pkg::PE_STORE;
      default: pe_idx = vseq_pkg::PE_ALU;
    endcase
  endfunction

  // Lowest free id
  always_comb begin
    next_id = '0;
    for (int i = vseq_pkg::NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id = vseq_pkg::vid_t'(i);
    end
  end

  assign full = &running_q;
  assign stall = issue.valid && !(&pe_ready_i);
  assign idle_o = ~|running_q;
  assign req_ready_o = (state_q == IDLE) && !stall && !full;
  assign accept = req_valid_i && req_ready_o;
  assign live = running_q & ~done_i;

  always_comb begin
    state_d = state_q;
    for (int p = 0; p < vseq_pkg::NR_PES; p++) begin
      pe_running_d[p] = pe_running_q[p] & ~done_i;
    end

    // Drop list entries whose instruction has finished
    rd_vid_d = rd_vid_q;
    wr_vid_d = wr_vid_q;
    for (int v = 0; v < 32; v++) begin
      rd_valid_d[v] = rd_valid_q[v] & live[rd_vid_q[v]];
      wr_valid_d[v] = wr_valid_q[v] & live[wr_vid_q[v]];
    end

    // Held request keeps its fields, hazards shrink as ids retire
    valid_d = stall;
    id_d = issue.id;
    op_d = issue.op;
    unit_d = issue.unit;
    vl_d = issue.vl;
    scalar_d = issue.scalar;
    hazard_d = issue.hazard & live;

    if (state_q == WAIT && resp_event_i) state_d = IDLE;

    if (accept) begin
      hazard_d = '0;
      // RAW
      if (dec.use_vs1 && wr_valid_d[dec.vs1]) hazard_d[wr_vid_d[dec.vs1]] = 1'b1;
      if (dec.use_vs2 && wr_valid_d[dec.vs2]) hazard_d[wr_vid_d[dec.vs2]] = 1'b1;
      // vm low means masked, which reads v0
      if (!dec.vm && wr_valid_d[vseq_pkg::VMASK]) begin
        hazard_d[wr_vid_d[vseq_pkg::VMASK]] = 1'b1;
      end
      // WAR and WAW
      if (dec.use_vd && rd_valid_d[dec.vd]) hazard_d[rd_vid_d[dec.vd]] = 1'b1;
      if (dec.use_vd && wr_valid_d[dec.vd]) hazard_d[wr_vid_d[dec.vd]] = 1'b1;

      valid_d = 1'b1;
      id_d = next_id;
      op_d = dec.op;
      unit_d = dec.unit;
      vl_d = dec.vl;
      scalar_d = dec.scalar;
      pe_running_d[pe_idx(dec.unit)][next_id] = 1'b1;

      if (dec.use_vd) begin
        wr_vid_d[dec.vd] = next_id;
        wr_valid_d[dec.vd] = 1'b1;
      end
      if (dec.use_vs1) begin
        rd_vid_d[dec.vs1] = next_id;
        rd_valid_d[dec.vs1] = 1'b1;
      end
      if (dec.use_vs2) begin
        rd_vid_d[dec.vs2] = next_id;
        rd_valid_d[dec.vs2] = 1'b1;
      end
      if (!dec.vm) begin
        rd_vid_d[vseq_pkg::VMASK] = next_id;
        rd_valid_d[vseq_pkg::VMASK] = 1'b1;
      end
      if (dec.needs_resp) state_d = WAIT;
    end

    running_d = '0;
    for (int p = 0; p < vseq_pkg::NR_PES; p++) begin
      running_d |= pe_running_d[p];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      pe_running_q <= '0;
      running_q <= '0;
      rd_valid_q <= '0;
      wr_valid_q <= '0;
      issue.valid <= 1'b0;
      issue.hazard <= '0;
      issue.running <= '0;
    end else begin
      state_q <= state_d;
      pe_running_q <= pe_running_d;
      running_q <= running_d;
      rd_valid_q <= rd_valid_d;
      wr_valid_q <= wr_valid_d;
      issue.valid <= valid_d;
      issue.hazard <= hazard_d;
      issue.running <= running_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_vid_q <= rd_vid_d;
    wr_vid_q <= wr_vid_d;
    issue.id <= id_d;
    issue.op <= op_d;
    issue.unit <= unit_d;
    issue.vl <= vl_d;
    issue.scalar <= scalar_d;
  end

  // A stalled issue keeps its request until the elements take it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall |=> issue.valid && $stable(issue.id) && $stable(issue.op) &&
              $stable(issue.unit) && $stable(issue.vl) && $stable(issue.scalar));

  // The id put on the issue side was free when it was handed out
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> issue.valid && issue.id == $past(next_id) && !$past(running_q[next_id]));

endmodule

/* vseq_decode.sv */
// Combinational decode of a dispatcher request.
// Classifies the operation by unit, register use and response need.
`timescale 1ns/1ps

module vseq_decode (
  vseq_issue_if.dec_mp    decoded,
  input  vseq_pkg::op_e   op_i,
  input  vseq_pkg::vreg_t vd_i,
  input  vseq_pkg::vreg_t vs1_i,
  input  vseq_pkg::vreg_t vs2_i,
  input  logic            vm_i,
  input  vseq_pkg::vl_t   vl_i,
  input  vseq_pkg::elen_t scalar_i
);

  always_comb begin
    decoded.op = op_i;
    decoded.vd = vd_i;
    decoded.vs1 = vs1_i;
    decoded.vs2 = vs2_i;
    decoded.vm = vm_i;
    decoded.vl = vl_i;
    decoded.scalar = scalar_i;

    decoded.unit = vseq_pkg::UNIT_ALU;
    decoded.use_vd = 1'b0;
    decoded.use_vs1 = 1'b0;
    decoded.use_vs2 = 1'b0;
    decoded.needs_resp = 1'b0;

    case (op_i)
      vseq_pkg::VADD, vseq_pkg::VMUL: begin
        decoded.use_vd = 1'b1;
        decoded.use_vs1 = 1'b1;
        decoded.use_vs2 = 1'b1;
      end
      vseq_pkg::VLE: begin
        decoded.unit = vseq_pkg::UNIT_LOAD;
        decoded.use_vd = 1'b1;
        decoded.needs_resp = 1'b1;
      end
      vseq_pkg::VSE: begin
        // vs1 holds the store data
        decoded.unit = vseq_pkg::UNIT_STORE;
        decoded.use_vs1 = 1'b1;
        decoded.needs_resp = 1'b1;
      end
      vseq_pkg::VREDSUM: begin
        // Scalar result, so no vd write
        decoded.use_vs2 = 1'b1;
        decoded.needs_resp = 1'b1;
      end
      default: ;
    endcase

    if (decoded.valid) begin
      assert (op_i inside {vseq_pkg::VADD, vseq_pkg::VMUL, vseq_pkg::VLE,
                           vseq_pkg::VSE, vseq_pkg::VREDSUM});
    end
  end

endmodule

/* vseq_issue_if.sv */
// Request bundle between decode, sequencer and processing elements.
// One instance carries the decoded request, a second the issued one.
`timescale 1ns/1ps

interface vseq_issue_if;

  logic valid;
  vseq_pkg::vid_t id;
  vseq_pkg::op_e op;
  vseq_pkg::unit_e unit;
  vseq_pkg::vreg_t vd;
  vseq_pkg::vreg_t vs1;
  vseq_pkg::vreg_t vs2;
  logic vm;
  vseq_pkg::vl_t vl;
  vseq_pkg::elen_t scalar;
  logic use_vd;
  logic use_vs1;
  logic use_vs2;
  logic needs_resp;
  // Hazard ids and the live running set, refreshed while a request is held
  vseq_pkg::vmask_t hazard;
  vseq_pkg::vmask_t running;

  modport dec_mp (
    input  valid,
    output op, unit, vd, vs1, vs2, vm, vl, scalar,
    output use_vd, use_vs1, use_vs2, needs_resp
  );

  modport seq_in_mp (
    input op, unit, vd, vs1, vs2, vm, vl, scalar,
    input use_vd, use_vs1, use_vs2, needs_resp
  );

  modport seq_out_mp (output valid, id, op, unit, vl, scalar, hazard, running);

  modport pe_mp (input valid, id, op, unit, vl, scalar, hazard, running);

endinterface

/* vseq_pkg.sv */
// Shared sizes, types and encodings of the vector sequencer subsystem.
// Every design file refers to these by scoped names.
package vseq_pkg;

  // Instruction ids that can be in flight at once
  localparam int unsigned NR_VINSN = 4;

  // Processing elements: arithmetic, load and store
  localparam int unsigned NR_PES = 3;

  // Element indices, chosen to match the unit encoding below
  localparam int unsigned PE_ALU = 0;
  localparam int unsigned PE_LOAD = 1;
  localparam int unsigned PE_STORE = 2;

  // v0 holds the mask of masked instructions
  localparam int unsigned VMASK = 0;

  typedef logic [1:0] vid_t;
  typedef logic [NR_VINSN-1:0] vmask_t;
  typedef logic [4:0] vreg_t;
  typedef logic [7:0] vl_t;
  typedef logic [31:0] elen_t;

  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VLE,
    VSE,
    VREDSUM
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

endpackage
